// File: src/lsu_lq_pkg.sv
// Load queue shared definitions
// Widths, queue depth, op codes, entry states and interface structs
package lsu_lq_pkg;

    // Widths and sizes used across the load queue
    localparam int ADDR_WIDTH    = 32;
    localparam int ROB_TAG_WIDTH = 5;
    localparam int MHQ_TAG_WIDTH = 2;
    localparam int LQ_DEPTH      = 8;
    localparam int LQ_IDX_WIDTH  = 3;
    // Native word size in bytes, the length of a full word load
    localparam int DATA_BYTES    = 4;

    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;
    typedef logic [MHQ_TAG_WIDTH-1:0] mhq_tag_t;
    typedef logic [LQ_IDX_WIDTH-1:0]  lq_idx_t;
    // One bit per entry, used both for one-hot selects and for status vectors
    typedef logic [LQ_DEPTH-1:0]      lq_mask_t;
    typedef logic [3:0]               lsu_op_t;

    // Load op codes, unsigned variants carry bit 2
    localparam lsu_op_t OP_LB  = 4'h0;
    localparam lsu_op_t OP_LH  = 4'h1;
    localparam lsu_op_t OP_LW  = 4'h2;
    localparam lsu_op_t OP_LBU = 4'h4;
    localparam lsu_op_t OP_LHU = 4'h5;

    // Life cycle of one queue entry
    typedef enum logic [2:0] {
        INVALID       = 3'd0,
        VALID         = 3'd1,
        MHQ_TAG_WAIT  = 3'd2,
        MHQ_FILL_WAIT = 3'd3,
        REPLAYABLE    = 3'd4,
        LAUNCHED      = 3'd5,
        COMPLETE      = 3'd6
    } lq_state_e;

    // New load from the LSU issue stage
    typedef struct packed {
        lsu_op_t  op;
        rob_tag_t tag;
        addr_t    addr;
    } lq_alloc_t;

    // Pipeline result for one entry, retry means the load did not finish
    typedef struct packed {
        lq_idx_t  lq_idx;
        logic     retry;
        logic     replay;
        mhq_tag_t mhq_tag;
        logic     mhq_retry;
        logic     mhq_replay;
    } lq_update_t;

    // Load sent back into the LSU pipeline
    typedef struct packed {
        lq_idx_t  lq_idx;
        lsu_op_t  op;
        rob_tag_t tag;
        addr_t    addr;
    } lq_replay_t;

    // Byte range of a retiring store, addr_end is exclusive
    typedef struct packed {
        addr_t addr;
        addr_t addr_end;
    } sq_retire_t;

endpackage

// File: src/lsu_lq_entry.sv
// Load queue entry
// Tracks one load from allocation through miss wait and replay until ROB retire
`timescale 1ns/10ps

module lsu_lq_entry (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_flush,
    input  logic                   i_alloc_sel,
    input  lsu_lq_pkg::lq_alloc_t  i_alloc,
    input  logic                   i_update_sel,
    input  lsu_lq_pkg::lq_update_t i_update,
    input  logic                   i_replay_sel,
    input  logic                   i_mhq_fill_en,
    input  lsu_lq_pkg::mhq_tag_t   i_mhq_fill_tag,
    input  logic                   i_sq_retire_en,
    input  lsu_lq_pkg::sq_retire_t i_sq_retire,
    input  logic                   i_rob_retire_en,
    input  lsu_lq_pkg::rob_tag_t   i_rob_retire_tag,
    output logic                   o_empty,
    output logic                   o_replayable,
    output lsu_lq_pkg::lq_alloc_t  o_fields,
    output logic                   o_retire_ack,
    output logic                   o_misspec
);

    import lsu_lq_pkg::*;

    // Current state and the stored load
    lq_state_e state_r;
    lq_state_e state_next;
    lq_state_e update_state;
    lq_alloc_t fields_r;
    mhq_tag_t  mhq_tag_r;
    logic      misspec_r;
    logic      misspec_next;

    // Byte range of the load used for the store overlap check
    addr_t     ld_start;
    addr_t     ld_end;
    logic      overlap;
    logic      mhq_waiting;
    logic      retire_hit;

    // The ROB retires this load only once it has completed and the tag matches
    assign retire_hit = i_rob_retire_en && (state_r == COMPLETE) &&
                        (fields_r.tag == i_rob_retire_tag);

    // Destination of an update from the LSU pipeline, with fill bypass
    always_comb begin
        update_state = COMPLETE;
        if (i_update.retry) begin
            if (i_update.replay || i_update.mhq_replay) begin
                // Fill already seen in the pipeline, replay right away
                update_state = REPLAYABLE;
            end else if (i_update.mhq_retry) begin
                // No MHQ slot was free, so any fill may free the line
                update_state = i_mhq_fill_en ? REPLAYABLE : MHQ_FILL_WAIT;
            end else if (i_mhq_fill_en && (i_update.mhq_tag == i_mhq_fill_tag)) begin
                // The fill for our own MHQ tag lands in the same cycle
                update_state = REPLAYABLE;
            end else begin
                update_state = MHQ_TAG_WAIT;
            end
        end
    end

    // Entry FSM
    always_comb begin
        state_next = state_r;
        case (state_r)
            INVALID: begin
                if (i_alloc_sel) begin
                    state_next = VALID;
                end
            end
            VALID, LAUNCHED: begin
                // Waiting on the pipeline result of the first or a replayed pass
                if (i_update_sel) begin
                    state_next = update_state;
                end
            end
            MHQ_TAG_WAIT: begin
                if (i_mhq_fill_en && (mhq_tag_r == i_mhq_fill_tag)) begin
                    state_next = REPLAYABLE;
                end
            end
            MHQ_FILL_WAIT: begin
                if (i_mhq_fill_en) begin
                    state_next = REPLAYABLE;
                end
            end
            REPLAYABLE: begin
                if (i_replay_sel) begin
                    state_next = LAUNCHED;
                end
            end
            COMPLETE: begin
                if (retire_hit) begin
                    state_next = INVALID;
                end
            end
            default: state_next = INVALID;
        endcase
        // A flush drops every load regardless of where it is
        if (i_flush) begin
            state_next = INVALID;
        end
    end

    // Use the incoming load when allocating so a same-cycle store is not missed
    always_comb begin
        lsu_op_t op;
        op = i_alloc_sel ? i_alloc.op : fields_r.op;
        ld_start = i_alloc_sel ? i_alloc.addr : fields_r.addr;
        case (op)
            OP_LB, OP_LBU: ld_end = ld_start + addr_t'(1);
            OP_LH, OP_LHU: ld_end = ld_start + addr_t'(2);
            default:       ld_end = ld_start + addr_t'(DATA_BYTES);
        endcase
    end

    // Two ranges overlap when either start falls inside the other range
    assign overlap = i_sq_retire_en &&
                     (((ld_start >= i_sq_retire.addr) && (ld_start < i_sq_retire.addr_end)) ||
                      ((i_sq_retire.addr >= ld_start) && (i_sq_retire.addr < ld_end)));

    // A load parked on the MHQ has not returned data yet and will read again
    assign mhq_waiting = (state_r == MHQ_TAG_WAIT) || (state_r == MHQ_FILL_WAIT) ||
                         (state_r == REPLAYABLE);

    // Allocation without overlap starts the entry with a clean bit
    assign misspec_next = !mhq_waiting && (overlap || (!i_alloc_sel && misspec_r));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= INVALID;
            misspec_r <= 1'b0;
        end else begin
            state_r   <= state_next;
            misspec_r <= misspec_next;
        end
    end

    // Load fields are captured on allocation, the MHQ tag on every update
    always_ff @(posedge clk) begin
        if (i_alloc_sel) begin
            fields_r <= i_alloc;
        end
        if (i_update_sel) begin
            mhq_tag_r <= i_update.mhq_tag;
        end
    end

    assign o_empty      = (state_r == INVALID);
    assign o_replayable = (state_r == REPLAYABLE);
    assign o_fields     = fields_r;
    assign o_retire_ack = retire_hit;
    assign o_misspec    = misspec_r;

endmodule

// File: src/lsu_lq_ctrl.sv
// Load queue controller
// Picks free entries, arbitrates replays round robin and merges retire results
`timescale 1ns/10ps

module lsu_lq_ctrl (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_alloc_en,
    input  logic                   i_update_en,
    input  lsu_lq_pkg::lq_idx_t    i_update_idx,
    input  lsu_lq_pkg::lq_mask_t   i_empty,
    input  lsu_lq_pkg::lq_mask_t   i_replayable,
    input  lsu_lq_pkg::lq_alloc_t  i_fields [lsu_lq_pkg::LQ_DEPTH],
    input  lsu_lq_pkg::lq_mask_t   i_retire_ack,
    input  lsu_lq_pkg::lq_mask_t   i_misspec,
    output lsu_lq_pkg::lq_mask_t   o_alloc_sel,
    output lsu_lq_pkg::lq_mask_t   o_update_sel,
    output lsu_lq_pkg::lq_mask_t   o_replay_sel,
    output logic                   o_full,
    output lsu_lq_pkg::lq_idx_t    o_alloc_idx,
    output logic                   o_replay_en,
    output lsu_lq_pkg::lq_replay_t o_replay,
    output logic                   o_rob_retire_ack,
    output logic                   o_rob_retire_misspec
);

    import lsu_lq_pkg::*;

    // Lowest free entry
    lq_idx_t  alloc_idx;

    // Round-robin replay arbitration
    lq_idx_t  rr_ptr_r;
    lq_idx_t  grant_idx;
    logic     grant_vld;

    // Scan from the top so the lowest empty index is the one left standing
    always_comb begin
        alloc_idx = '0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            if (i_empty[i]) begin
                alloc_idx = lq_idx_t'(i);
            end
        end
    end

    // Queue is full once no entry reports empty
    assign o_full      = ~|i_empty;
    assign o_alloc_idx = alloc_idx;

    // The LSU never allocates into a full queue, so the index is always free here
    assign o_alloc_sel = i_alloc_en ? (lq_mask_t'(1) << alloc_idx) : '0;

    // Update names its entry directly
    assign o_update_sel = i_update_en ? (lq_mask_t'(1) << i_update_idx) : '0;

    // Search starting at the pointer, the closest replayable entry wins
    // Index arithmetic wraps because the depth is a power of two
    always_comb begin
        lq_idx_t idx;
        grant_idx = '0;
        grant_vld = 1'b0;
        for (int k = LQ_DEPTH - 1; k >= 0; k--) begin
            idx = rr_ptr_r + lq_idx_t'(k);
            if (i_replayable[idx]) begin
                grant_idx = idx;
                grant_vld = 1'b1;
            end
        end
    end

    // Pointer moves just past the last grant
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rr_ptr_r <= '0;
        end else if (grant_vld) begin
            rr_ptr_r <= grant_idx + lq_idx_t'(1);
        end
    end

    // Replay goes out in the same cycle, the LSU always takes it
    assign o_replay_en  = grant_vld;
    assign o_replay_sel = grant_vld ? (lq_mask_t'(1) << grant_idx) : '0;

    always_comb begin
        o_replay.lq_idx = grant_idx;
        o_replay.op     = i_fields[grant_idx].op;
        o_replay.tag    = i_fields[grant_idx].tag;
        o_replay.addr   = i_fields[grant_idx].addr;
    end

    // At most one entry holds a given ROB tag, so the OR picks its misspec bit
    assign o_rob_retire_ack     = |i_retire_ack;
    assign o_rob_retire_misspec = |(i_retire_ack & i_misspec);

endmodule

// File: src/lsu_lq.sv
// Load queue top level
// Controller plus one entry per queue slot, broadcasts fan out to every entry
`timescale 1ns/10ps

module lsu_lq (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_flush,
    input  logic                   i_alloc_en,
    input  lsu_lq_pkg::lq_alloc_t  i_alloc,
    input  logic                   i_update_en,
    input  lsu_lq_pkg::lq_update_t i_update,
    input  logic                   i_mhq_fill_en,
    input  lsu_lq_pkg::mhq_tag_t   i_mhq_fill_tag,
    input  logic                   i_sq_retire_en,
    input  lsu_lq_pkg::sq_retire_t i_sq_retire,
    input  logic                   i_rob_retire_en,
    input  lsu_lq_pkg::rob_tag_t   i_rob_retire_tag,
    output logic                   o_full,
    output lsu_lq_pkg::lq_idx_t    o_alloc_idx,
    output logic                   o_replay_en,
    output lsu_lq_pkg::lq_replay_t o_replay,
    output logic                   o_rob_retire_ack,
    output logic                   o_rob_retire_misspec
);

    import lsu_lq_pkg::*;

    // One-hot selects from the controller to the entries
    lq_mask_t  alloc_sel;
    lq_mask_t  update_sel;
    lq_mask_t  replay_sel;

    // Status gathered from every entry
    lq_mask_t  entry_empty;
    lq_mask_t  entry_replayable;
    lq_mask_t  entry_retire_ack;
    lq_mask_t  entry_misspec;
    lq_alloc_t entry_fields [LQ_DEPTH];

    lsu_lq_ctrl lsu_lq_ctrl_inst (
        .clk                  (clk),
        .i_rst_n              (i_rst_n),
        .i_alloc_en           (i_alloc_en),
        .i_update_en          (i_update_en),
        .i_update_idx         (i_update.lq_idx),
        .i_empty              (entry_empty),
        .i_replayable         (entry_replayable),
        .i_fields             (entry_fields),
        .i_retire_ack         (entry_retire_ack),
        .i_misspec            (entry_misspec),
        .o_alloc_sel          (alloc_sel),
        .o_update_sel         (update_sel),
        .o_replay_sel         (replay_sel),
        .o_full               (o_full),
        .o_alloc_idx          (o_alloc_idx),
        .o_replay_en          (o_replay_en),
        .o_replay             (o_replay),
        .o_rob_retire_ack     (o_rob_retire_ack),
        .o_rob_retire_misspec (o_rob_retire_misspec)
    );

    // Entries see the full update and all broadcasts, only the select is per entry
    for (genvar g = 0; g < LQ_DEPTH; g++) begin : g_entry
        lsu_lq_entry entry_inst (
            .clk              (clk),
            .i_rst_n          (i_rst_n),
            .i_flush          (i_flush),
            .i_alloc_sel      (alloc_sel[g]),
            .i_alloc          (i_alloc),
            .i_update_sel     (update_sel[g]),
            .i_update         (i_update),
            .i_replay_sel     (replay_sel[g]),
            .i_mhq_fill_en    (i_mhq_fill_en),
            .i_mhq_fill_tag   (i_mhq_fill_tag),
            .i_sq_retire_en   (i_sq_retire_en),
            .i_sq_retire      (i_sq_retire),
            .i_rob_retire_en  (i_rob_retire_en),
            .i_rob_retire_tag (i_rob_retire_tag),
            .o_empty          (entry_empty[g]),
            .o_replayable     (entry_replayable[g]),
            .o_fields         (entry_fields[g]),
            .o_retire_ack     (entry_retire_ack[g]),
            .o_misspec        (entry_misspec[g])
        );
    end

endmodule

// File: verif/lsu_lq_tb.sv
// Load queue testbench
// Drives alloc, update, fill, store and ROB retire traffic against a scoreboard model
`timescale 1ns/10ps

module lsu_lq_tb;

    import lsu_lq_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic       clk;
    logic       i_rst_n;
    logic       i_flush;
    logic       i_alloc_en;
    lq_alloc_t  i_alloc;
    logic       i_update_en;
    lq_update_t i_update;
    logic       i_mhq_fill_en;
    mhq_tag_t   i_mhq_fill_tag;
    logic       i_sq_retire_en;
    sq_retire_t i_sq_retire;
    logic       i_rob_retire_en;
    rob_tag_t   i_rob_retire_tag;
    logic       o_full;
    lq_idx_t    o_alloc_idx;
    logic       o_replay_en;
    lq_replay_t o_replay;
    logic       o_rob_retire_ack;
    logic       o_rob_retire_misspec;

    // Scoreboard view of the queue and the replay pointer the DUT should hold
    logic        model_busy [LQ_DEPTH];
    lq_alloc_t   model_fields [LQ_DEPTH];
    lq_idx_t     model_rr;
    logic [31:0] lcg_state;
    int          errors;
    int          test_errors;
    int          tests_run;
    string       cur_test;

    lsu_lq lsu_lq_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic lsu_op_t rand_op();
        case (lcg_next() % 32'd5)
            32'd0:   return OP_LB;
            32'd1:   return OP_LH;
            32'd2:   return OP_LW;
            32'd3:   return OP_LBU;
            default: return OP_LHU;
        endcase
    endfunction

    // Word aligned and well clear of the top of memory so ranges never wrap
    function automatic addr_t rand_addr();
        return (lcg_next() & 32'h0fff_fffc) | 32'h0000_1000;
    endfunction

    function automatic addr_t load_len(lsu_op_t op);
        if (op == OP_LB || op == OP_LBU) return 32'd1;
        if (op == OP_LH || op == OP_LHU) return 32'd2;
        return addr_t'(DATA_BYTES);
    endfunction

    // Half-open ranges share a byte when each starts before the other ends
    function automatic logic ranges_overlap(addr_t ls, addr_t le, addr_t ss, addr_t se);
        return (ls < se) && (ss < le);
    endfunction

    function automatic lq_idx_t lowest_free();
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (!model_busy[i]) return lq_idx_t'(i);
        end
        return '0;
    endfunction

    // First set bit at or after the pointer with wrap around the queue
    function automatic lq_idx_t expected_grant(lq_mask_t mask, lq_idx_t ptr);
        lq_idx_t idx;
        for (int k = 0; k < LQ_DEPTH; k++) begin
            idx = ptr + lq_idx_t'(k);
            if (mask[idx]) return idx;
        end
        return ptr;
    endfunction

    task automatic check_bit(string label, logic exp, logic act);
        assert (act === exp) else begin
            $display("ERROR %s %s expected %0b actual %0b", cur_test, label, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_idx(string label, lq_idx_t exp, lq_idx_t act);
        assert (act === exp) else begin
            $display("ERROR %s %s expected %0d actual %0d", cur_test, label, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_replay(lq_replay_t exp, lq_replay_t act);
        assert (act === exp) else begin
            $display("ERROR %s replay expected %h actual %h", cur_test, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic clear_inputs();
        i_flush         = 1'b0;
        i_alloc_en      = 1'b0;
        i_alloc         = '0;
        i_update_en     = 1'b0;
        i_update        = '0;
        i_mhq_fill_en   = 1'b0;
        i_mhq_fill_tag  = '0;
        i_sq_retire_en  = 1'b0;
        i_sq_retire     = '0;
        i_rob_retire_en = 1'b0;
        i_rob_retire_tag = '0;
    endtask

    // Strobes last one cycle, so every new cycle starts from idle inputs
    task automatic tick();
        @(posedge clk);
        #1;
        clear_inputs();
    endtask

    // Combinational responses are read mid cycle well after the inputs moved
    task automatic settle();
        @(negedge clk);
    endtask

    task automatic alloc_load(lsu_op_t op, rob_tag_t tag, addr_t addr, output lq_idx_t idx);
        check_bit("full before alloc", 1'b0, o_full);
        idx = lowest_free();
        check_idx("alloc_idx", idx, o_alloc_idx);
        i_alloc_en   = 1'b1;
        i_alloc.op   = op;
        i_alloc.tag  = tag;
        i_alloc.addr = addr;
        model_busy[idx]   = 1'b1;
        model_fields[idx] = i_alloc;
    endtask

    task automatic update_entry(lq_idx_t idx, logic retry, logic replay, mhq_tag_t mtag,
                                logic mhq_retry, logic mhq_replay);
        i_update_en         = 1'b1;
        i_update.lq_idx     = idx;
        i_update.retry      = retry;
        i_update.replay     = replay;
        i_update.mhq_tag    = mtag;
        i_update.mhq_retry  = mhq_retry;
        i_update.mhq_replay = mhq_replay;
    endtask

    task automatic fill(mhq_tag_t tag);
        i_mhq_fill_en  = 1'b1;
        i_mhq_fill_tag = tag;
    endtask

    task automatic store_retire(addr_t addr, addr_t addr_end);
        i_sq_retire_en       = 1'b1;
        i_sq_retire.addr     = addr;
        i_sq_retire.addr_end = addr_end;
    endtask

    task automatic retire_check(rob_tag_t tag, logic exp_ack, logic exp_misspec);
        tick();
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
        settle();
        check_bit("retire ack", exp_ack, o_rob_retire_ack);
        check_bit("retire misspec", exp_misspec, o_rob_retire_misspec);
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (exp_ack && model_busy[i] && model_fields[i].tag == tag) model_busy[i] = 1'b0;
        end
    endtask

    // One grant per cycle until every woken entry has gone out and silence after that
    task automatic expect_replays(lq_mask_t mask);
        lq_idx_t    idx;
        lq_replay_t exp;
        while (mask != '0) begin
            settle();
            idx = expected_grant(mask, model_rr);
            exp.lq_idx = idx;
            exp.op     = model_fields[idx].op;
            exp.tag    = model_fields[idx].tag;
            exp.addr   = model_fields[idx].addr;
            check_bit("replay_en", 1'b1, o_replay_en);
            check_replay(exp, o_replay);
            mask[idx] = 1'b0;
            model_rr  = idx + lq_idx_t'(1);
            tick();
        end
        settle();
        check_bit("replay_en idle", 1'b0, o_replay_en);
    endtask

    task automatic begin_test(string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    // Every test leaves an empty queue behind for the next one
    task automatic end_test();
        tick();
        i_flush = 1'b1;
        tick();
        for (int i = 0; i < LQ_DEPTH; i++) model_busy[i] = 1'b0;
        tests_run++;
        if (test_errors == 0) $display("test %s passed", cur_test);
        else $display("test %s failed with %0d errors", cur_test, test_errors);
    endtask

    task automatic test_fill_order();
        rob_tag_t tags [LQ_DEPTH];
        rob_tag_t base;
        lq_idx_t  idx;
        begin_test("fill_order");
        settle();
        check_bit("full after reset", 1'b0, o_full);
        check_idx("alloc_idx after reset", '0, o_alloc_idx);
        check_bit("replay_en after reset", 1'b0, o_replay_en);
        base = rob_tag_t'(lcg_next());
        for (int i = 0; i < LQ_DEPTH; i++) begin
            tick();
            tags[i] = base + rob_tag_t'(i);
            alloc_load(rand_op(), tags[i], rand_addr(), idx);
        end
        tick();
        check_bit("full", 1'b1, o_full);
        // Retiring entry 3 opens a hole in the middle of a full queue
        update_entry(3'd3, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        retire_check(tags[3], 1'b1, 1'b0);
        tick();
        check_bit("full after retire", 1'b0, o_full);
        alloc_load(rand_op(), tags[3], rand_addr(), idx);
        tick();
        check_bit("full after refill", 1'b1, o_full);
        end_test();
    endtask

    task automatic test_complete_retire();
        rob_tag_t tag;
        lq_idx_t  idx;
        begin_test("complete_retire");
        tag = rob_tag_t'(lcg_next());
        tick();
        alloc_load(rand_op(), tag, rand_addr(), idx);
        tick();
        update_entry(idx, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        retire_check(tag ^ 5'h01, 1'b0, 1'b0);
        check_bit("replay_en while complete", 1'b0, o_replay_en);
        retire_check(tag, 1'b1, 1'b0);
        tick();
        check_idx("alloc_idx after retire", lowest_free(), o_alloc_idx);
        // The tag left with the entry, so a second retire finds nothing
        retire_check(tag, 1'b0, 1'b0);
        end_test();
    endtask

    task automatic test_tag_wait();
        rob_tag_t base;
        lq_idx_t  idx;
        begin_test("tag_wait");
        base = rob_tag_t'(lcg_next());
        for (int i = 0; i < 4; i++) begin
            tick();
            alloc_load(rand_op(), base + rob_tag_t'(i), rand_addr(), idx);
        end
        // Entries 0 to 2 miss on MHQ tag 2 and entry 3 on tag 1
        for (int i = 0; i < 4; i++) begin
            tick();
            update_entry(lq_idx_t'(i), 1'b1, 1'b0, (i == 3) ? 2'd1 : 2'd2, 1'b0, 1'b0);
        end
        tick();
        fill(2'd3);
        tick();
        settle();
        check_bit("replay_en on foreign fill", 1'b0, o_replay_en);
        tick();
        fill(2'd2);
        tick();
        expect_replays(8'h07);
        // Entry 0 misses again on tag 1 so the next fill wakes it together with entry 3
        // The pointer now sits at 3, so entry 3 must go out before entry 0
        tick();
        update_entry(3'd0, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0);
        tick();
        fill(2'd1);
        tick();
        expect_replays(8'h09);
        // A replayed load can still finish and retire normally
        tick();
        update_entry(3'd1, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        retire_check(base + 5'd1, 1'b1, 1'b0);
        end_test();
    endtask

    task automatic test_fill_wait();
        rob_tag_t base;
        lq_idx_t  idx;
        begin_test("fill_wait");
        base = rob_tag_t'(lcg_next());
        for (int i = 0; i < 3; i++) begin
            tick();
            alloc_load(rand_op(), base + rob_tag_t'(i), rand_addr(), idx);
        end
        tick();
        update_entry(3'd0, 1'b1, 1'b0, 2'd0, 1'b1, 1'b0);
        // Entry 1 meets a fill in its update cycle and skips the wait
        tick();
        fill(mhq_tag_t'(lcg_next()));
        update_entry(3'd1, 1'b1, 1'b0, 2'd0, 1'b1, 1'b0);
        tick();
        expect_replays(8'h03);
        tick();
        fill(2'd1);
        update_entry(3'd2, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0);
        tick();
        expect_replays(8'h04);
        // The pipeline already saw the fill, so the load goes straight back out
        tick();
        update_entry(3'd0, 1'b1, 1'b0, 2'd0, 1'b0, 1'b1);
        tick();
        expect_replays(8'h01);
        end_test();
    endtask

    task automatic test_misspec();
        rob_tag_t base;
        addr_t    addr_a;
        addr_t    addr_b;
        addr_t    st;
        lq_idx_t  ia;
        lq_idx_t  ib;
        begin_test("misspec");
        base   = rob_tag_t'(lcg_next());
        addr_a = rand_addr();
        tick();
        alloc_load(OP_LB, base, addr_a, ia);
        tick();
        alloc_load(OP_LW, base + 5'd1, addr_a, ib);
        tick();
        update_entry(ia, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        tick();
        update_entry(ib, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        // Store hits the byte just past the byte load and inside the word load
        st = addr_a + load_len(OP_LB);
        tick();
        store_retire(st, st + 32'd1);
        retire_check(base, 1'b1, ranges_overlap(addr_a, addr_a + load_len(OP_LB), st, st + 1));
        retire_check(base + 5'd1, 1'b1,
                     ranges_overlap(addr_a, addr_a + load_len(OP_LW), st, st + 1));
        // Store retiring in the same cycle as the allocation
        addr_b = rand_addr();
        tick();
        alloc_load(OP_LH, base + 5'd2, addr_b, ia);
        store_retire(addr_b + 32'd1, addr_b + 32'd3);
        tick();
        update_entry(ia, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        retire_check(base + 5'd2, 1'b1, ranges_overlap(addr_b, addr_b + load_len(OP_LH),
                                                        addr_b + 32'd1, addr_b + 32'd3));
        end_test();
    endtask

    task automatic test_flush();
        rob_tag_t base;
        lq_idx_t  idx;
        begin_test("flush");
        base = rob_tag_t'(lcg_next());
        for (int i = 0; i < 4; i++) begin
            tick();
            alloc_load(rand_op(), base + rob_tag_t'(i), rand_addr(), idx);
        end
        tick();
        update_entry(3'd0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        tick();
        update_entry(3'd1, 1'b0, 1'b0, '0, 1'b0, 1'b0);
        tick();
        update_entry(3'd2, 1'b1, 1'b0, 2'd3, 1'b0, 1'b0);
        tick();
        i_flush = 1'b1;
        for (int i = 0; i < LQ_DEPTH; i++) model_busy[i] = 1'b0;
        tick();
        check_bit("full after flush", 1'b0, o_full);
        check_idx("alloc_idx after flush", '0, o_alloc_idx);
        // The parked miss is gone, so its fill must wake nothing
        fill(2'd3);
        tick();
        settle();
        check_bit("replay_en after flush", 1'b0, o_replay_en);
        for (int i = 0; i < 4; i++) retire_check(base + rob_tag_t'(i), 1'b0, 1'b0);
        end_test();
    endtask

    initial begin
        clk       = 1'b0;
        i_rst_n   = 1'b0;
        clear_inputs();
        lcg_state = 32'hce77;
        errors    = 0;
        tests_run = 0;
        model_rr  = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            model_busy[i]   = 1'b0;
            model_fields[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        test_fill_order();
        test_complete_retire();
        test_tag_wait();
        test_fill_wait();
        test_misspec();
        test_flush();
        $display("tests run %0d, failed checks %0d", tests_run, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Upper bound on run time with room to spare for every test
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: lsu_lq.f
src/lsu_lq_pkg.sv
src/lsu_lq_entry.sv
src/lsu_lq_ctrl.sv
src/lsu_lq.sv
verif/lsu_lq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the load queue testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module lsu_lq_tb -f lsu_lq.f -o lsu_lq_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/lsu_lq_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
